// ==== chimney_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared sizes, channel encoding and the AXI and flit structs
// of the manager chimney. Modules take it by wildcard import.
////////////////////////////////////////////////////////////

package chimney_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned IdWidth     = 4;
  localparam int unsigned LenWidth    = 8;
  localparam int unsigned RespWidth   = 2;
  localparam int unsigned NodeIdWidth = 2;

  // Address bits [NodeSelLsb +: NodeIdWidth] select the target node
  localparam int unsigned NodeSelLsb = 28;

  // Outstanding transactions per direction
  localparam int unsigned MaxTxns  = 4;
  localparam int unsigned CntWidth = $clog2(MaxTxns + 1);

  typedef logic [NodeIdWidth-1:0] node_id_t;

  typedef enum logic [2:0] {
    ChAw,
    ChW,
    ChAr,
    ChB,
    ChR
  } axi_ch_e;

  ////////////////////////////////////////////////////////////
  // AXI channels
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [IdWidth-1:0]   id;
    logic [LenWidth-1:0]  len;
  } axi_aw_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [IdWidth-1:0]   id;
    logic [LenWidth-1:0]  len;
  } axi_ar_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } axi_w_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [RespWidth-1:0] resp;
  } axi_b_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic [RespWidth-1:0] resp;
    logic                 last;
  } axi_r_t;

  // Core to chimney
  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    axi_ar_t ar;
    logic    ar_valid;
    logic    b_ready;
    logic    r_ready;
  } axi_req_t;

  // Chimney to core
  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    logic   ar_ready;
    axi_b_t b;
    logic   b_valid;
    axi_r_t r;
    logic   r_valid;
  } axi_rsp_t;

  ////////////////////////////////////////////////////////////
  // Flits
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } flit_hdr_t;

  // Unused fields of a channel are zero
  typedef struct packed {
    flit_hdr_t            hdr;
    logic [AddrWidth-1:0] addr;
    logic [IdWidth-1:0]   id;
    logic [LenWidth-1:0]  len;
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
  } req_flit_t;

  typedef struct packed {
    flit_hdr_t            hdr;
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic [RespWidth-1:0] resp;
  } rsp_flit_t;

  typedef struct packed {
    logic      valid;
    req_flit_t flit;
  } req_link_t;

  typedef struct packed {
    logic      valid;
    rsp_flit_t flit;
  } rsp_link_t;

  // Fixed address map: node number sits in the upper address bits
  function automatic node_id_t addr_to_node(input logic [AddrWidth-1:0] addr);
    return addr[NodeSelLsb +: NodeIdWidth];
  endfunction

endpackage

// ==== files.f ====
chimney_pkg.sv
write_packer.sv
read_packer.sv
req_wormhole_arbiter.sv
rsp_unpacker.sv
floo_chimney_top.sv
tb_chimney.sv

// ==== floo_chimney_top.sv ====
////////////////////////////////////////////////////////////
// Manager-side chimney. AXI requests from the core leave as
// request flits, response flits come back as B and R beats.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_chimney_top import chimney_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  node_id_t  node_id_i,
  input  axi_req_t  axi_in_req_i,
  output axi_rsp_t  axi_in_rsp_o,
  output req_link_t floo_req_o,
  input  logic      floo_req_ready_i,
  input  rsp_link_t floo_rsp_i,
  output logic      floo_rsp_ready_o
);

  req_flit_t wr_flit, rd_flit;
  logic      wr_valid, wr_ready;
  logic      rd_valid, rd_ready;
  logic      aw_ready, w_ready, ar_ready;
  axi_b_t    b;
  axi_r_t    r;
  logic      b_valid, r_valid;
  logic      b_done, r_done;

  assign axi_in_rsp_o = '{
    aw_ready: aw_ready,
    w_ready:  w_ready,
    ar_ready: ar_ready,
    b:        b,
    b_valid:  b_valid,
    r:        r,
    r_valid:  r_valid
  };

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////

  write_packer i_write_packer (
    .clk_i        ( clk_i                 ),
    .reset_i      ( reset_i               ),
    .node_id_i    ( node_id_i             ),
    .aw_i         ( axi_in_req_i.aw       ),
    .aw_valid_i   ( axi_in_req_i.aw_valid ),
    .aw_ready_o   ( aw_ready              ),
    .w_i          ( axi_in_req_i.w        ),
    .w_valid_i    ( axi_in_req_i.w_valid  ),
    .w_ready_o    ( w_ready               ),
    .b_done_i     ( b_done                ),
    .flit_o       ( wr_flit               ),
    .flit_valid_o ( wr_valid              ),
    .flit_ready_i ( wr_ready              )
  );

  read_packer i_read_packer (
    .clk_i        ( clk_i                 ),
    .reset_i      ( reset_i               ),
    .node_id_i    ( node_id_i             ),
    .ar_i         ( axi_in_req_i.ar       ),
    .ar_valid_i   ( axi_in_req_i.ar_valid ),
    .ar_ready_o   ( ar_ready              ),
    .r_done_i     ( r_done                ),
    .flit_o       ( rd_flit               ),
    .flit_valid_o ( rd_valid              ),
    .flit_ready_i ( rd_ready              )
  );

  req_wormhole_arbiter i_req_arbiter (
    .clk_i        ( clk_i            ),
    .reset_i      ( reset_i          ),
    .wr_flit_i    ( wr_flit          ),
    .wr_valid_i   ( wr_valid         ),
    .wr_ready_o   ( wr_ready         ),
    .rd_flit_i    ( rd_flit          ),
    .rd_valid_i   ( rd_valid         ),
    .rd_ready_o   ( rd_ready         ),
    .link_o       ( floo_req_o       ),
    .link_ready_i ( floo_req_ready_i )
  );

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  rsp_unpacker i_rsp_unpacker (
    .clk_i            ( clk_i                ),
    .reset_i          ( reset_i              ),
    .floo_rsp_i       ( floo_rsp_i           ),
    .floo_rsp_ready_o ( floo_rsp_ready_o     ),
    .b_o              ( b                    ),
    .b_valid_o        ( b_valid              ),
    .b_ready_i        ( axi_in_req_i.b_ready ),
    .r_o              ( r                    ),
    .r_valid_o        ( r_valid              ),
    .r_ready_i        ( axi_in_req_i.r_ready ),
    .b_done_o         ( b_done               ),
    .r_done_o         ( r_done               )
  );

endmodule

// ==== read_packer.sv ====
////////////////////////////////////////////////////////////
// Turns each AR beat into a single-flit request packet and
// limits the number of reads waiting for their last R beat.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module read_packer import chimney_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  node_id_t  node_id_i,
  input  axi_ar_t   ar_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  logic      r_done_i,
  output req_flit_t flit_o,
  output logic      flit_valid_o,
  input  logic      flit_ready_i
);

  logic [CntWidth-1:0] cnt_q;
  logic                full;
  logic                ar_fire;

  assign full         = (cnt_q == CntWidth'(MaxTxns));
  assign flit_valid_o = ar_valid_i && !full;
  assign ar_ready_o   = !full && flit_ready_i;
  assign ar_fire      = ar_valid_i && ar_ready_o;

  always_comb begin
    flit_o            = '0;
    flit_o.hdr.dst_id = addr_to_node(ar_i.addr);
    flit_o.hdr.src_id = node_id_i;
    flit_o.hdr.axi_ch = ChAr;
    flit_o.hdr.last   = 1'b1;
    flit_o.addr       = ar_i.addr;
    flit_o.id         = ar_i.id;
    flit_o.len        = ar_i.len;
  end

  // Outstanding reads
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (ar_fire && !r_done_i) begin
      cnt_q <= cnt_q + CntWidth'(1);
    end else if (!ar_fire && r_done_i) begin
      cnt_q <= cnt_q - CntWidth'(1);
    end
  end

  r_done_pending_a: assert property (@(posedge clk_i) disable iff (reset_i)
    r_done_i |-> cnt_q != '0);

endmodule

// ==== req_wormhole_arbiter.sv ====
////////////////////////////////////////////////////////////
// Round-robin between write and read packets on the request
// link. A packet keeps the link until its last flit is out.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module req_wormhole_arbiter import chimney_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  req_flit_t wr_flit_i,
  input  logic      wr_valid_i,
  output logic      wr_ready_o,
  input  req_flit_t rd_flit_i,
  input  logic      rd_valid_i,
  output logic      rd_ready_o,
  output req_link_t link_o,
  input  logic      link_ready_i
);

  // Selection encoding: 0 picks the write side, 1 the read side
  logic lock_q, lock_d;
  logic sel_q;
  logic prio_q, prio_d;
  logic sel;
  logic fire;

  always_comb begin
    if (lock_q) begin
      sel = sel_q;
    end else if (wr_valid_i && rd_valid_i) begin
      sel = prio_q;
    end else begin
      sel = rd_valid_i;
    end
  end

  assign link_o.valid = sel ? rd_valid_i : wr_valid_i;
  assign link_o.flit  = sel ? rd_flit_i : wr_flit_i;
  assign wr_ready_o   = !sel && link_ready_i;
  assign rd_ready_o   = sel && link_ready_i;
  assign fire         = link_o.valid && link_ready_i;

  // Hold the grant during a stall and inside a packet
  always_comb begin
    lock_d = lock_q;
    prio_d = prio_q;
    if (link_o.valid) lock_d = !(link_ready_i && link_o.flit.hdr.last);
    if (fire && link_o.flit.hdr.last) prio_d = !sel;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
      sel_q  <= 1'b0;
      prio_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
      sel_q  <= sel;
      prio_q <= prio_d;
    end
  end

  link_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    link_o.valid && !link_ready_i |=> link_o.valid && $stable(link_o.flit));

endmodule

// ==== rsp_unpacker.sv ====
////////////////////////////////////////////////////////////
// Steers response flits to the AXI B or R channel and flags
// completed writes and reads back to the packers.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rsp_unpacker import chimney_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  rsp_link_t floo_rsp_i,
  output logic      floo_rsp_ready_o,
  output axi_b_t    b_o,
  output logic      b_valid_o,
  input  logic      b_ready_i,
  output axi_r_t    r_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output logic      b_done_o,
  output logic      r_done_o
);

  logic is_b, is_r;

  assign is_b = (floo_rsp_i.flit.hdr.axi_ch == ChB);
  assign is_r = (floo_rsp_i.flit.hdr.axi_ch == ChR);

  assign b_valid_o = floo_rsp_i.valid && is_b;
  assign r_valid_o = floo_rsp_i.valid && is_r;

  assign b_o.id   = floo_rsp_i.flit.id;
  assign b_o.resp = floo_rsp_i.flit.resp;

  assign r_o.id   = floo_rsp_i.flit.id;
  assign r_o.data = floo_rsp_i.flit.data;
  assign r_o.resp = floo_rsp_i.flit.resp;
  // R bursts end where the packet ends
  assign r_o.last = floo_rsp_i.flit.hdr.last;

  assign floo_rsp_ready_o = (is_b && b_ready_i) || (is_r && r_ready_i);

  // Completion pulses for the outstanding counters
  assign b_done_o = b_valid_o && b_ready_i;
  assign r_done_o = r_valid_o && r_ready_i && r_o.last;

  rsp_channel_a: assert property (@(posedge clk_i) disable iff (reset_i)
    floo_rsp_i.valid |-> (is_b || is_r));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the chimney testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_chimney \
  -o sim_chimney > build.log 2>&1 &&
./obj_dir/sim_chimney 2>&1 | tee sim.log ||
{ echo "Build or run failed, see build.log"; exit 1; }
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_chimney.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the manager chimney. Drives AXI
// requests and response flits, checks flits and AXI beats.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_chimney import chimney_pkg::*; ();

  // The tests need well under 100 cycles
  localparam int unsigned TimeoutCycles = 2000;

  logic      clk;
  logic      reset;
  node_id_t  node_id;
  axi_req_t  axi_req;
  axi_rsp_t  axi_rsp;
  req_link_t floo_req;
  logic      floo_req_ready;
  rsp_link_t floo_rsp;
  logic      floo_rsp_ready;

  int          errors;
  int          checks;
  int          cycles = 0;
  int          reads_open;
  logic [31:0] lcg_state;
  logic        aw_sent;
  time         w_last_time;
  time         ar_time;

  floo_chimney_top dut_i (
    .clk_i            ( clk            ),
    .reset_i          ( reset          ),
    .node_id_i        ( node_id        ),
    .axi_in_req_i     ( axi_req        ),
    .axi_in_rsp_o     ( axi_rsp        ),
    .floo_req_o       ( floo_req       ),
    .floo_req_ready_i ( floo_req_ready ),
    .floo_rsp_i       ( floo_rsp       ),
    .floo_rsp_ready_o ( floo_rsp_ready )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Target node sits above the offset
  function automatic logic [AddrWidth-1:0] make_addr(input node_id_t dst,
                                                     input logic [NodeSelLsb-1:0] offset);
    return (AddrWidth'(dst) << NodeSelLsb) | AddrWidth'(offset);
  endfunction

  function automatic req_flit_t make_req_flit(
    input axi_ch_e              ch,
    input node_id_t             dst,
    input logic                 last,
    input logic [AddrWidth-1:0] addr,
    input logic [IdWidth-1:0]   id,
    input logic [LenWidth-1:0]  len,
    input logic [DataWidth-1:0] data,
    input logic [StrbWidth-1:0] strb
  );
    req_flit_t f;
    f            = '0;
    f.hdr.dst_id = dst;
    f.hdr.src_id = node_id;
    f.hdr.axi_ch = ch;
    f.hdr.last   = last;
    f.addr       = addr;
    f.id         = id;
    f.len        = len;
    f.data       = data;
    f.strb       = strb;
    return f;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s: expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_req_flit(input string name, input req_flit_t exp, input req_flit_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_b(input string name, input axi_b_t exp, input axi_b_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_r(input string name, input axi_r_t exp, input axi_r_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic start_read(input axi_ar_t ar);
    @(posedge clk);
    axi_req.ar       <= ar;
    axi_req.ar_valid <= 1'b1;
  endtask

  // Waits for the AR handshake and checks the flit that leaves with it
  task automatic finish_read(input axi_ar_t ar, input node_id_t dst);
    req_flit_t exp;
    exp = make_req_flit(ChAr, dst, 1'b1, ar.addr, ar.id, ar.len, '0, '0);
    @(negedge clk);
    while (!axi_rsp.ar_ready) @(negedge clk);
    check_bit("floo_req_o.valid", 1'b1, floo_req.valid);
    check_req_flit("floo_req_o.flit", exp, floo_req.flit);
    @(posedge clk);
    axi_req.ar_valid <= 1'b0;
    ar_time = $time;
    reads_open++;
  endtask

  task automatic write_burst(input node_id_t dst, input logic [NodeSelLsb-1:0] offset,
                             input logic [IdWidth-1:0] id, input int beats);
    axi_aw_t     aw;
    axi_w_t      w;
    logic [31:0] rnd;
    req_flit_t   exp;
    aw.addr = make_addr(dst, offset);
    aw.id   = id;
    aw.len  = LenWidth'(beats - 1);
    @(posedge clk);
    axi_req.aw       <= aw;
    axi_req.aw_valid <= 1'b1;
    @(negedge clk);
    while (!axi_rsp.aw_ready) @(negedge clk);
    exp = make_req_flit(ChAw, dst, 1'b0, aw.addr, aw.id, aw.len, '0, '0);
    check_req_flit("floo_req_o.flit", exp, floo_req.flit);
    check_bit("w_ready", 1'b0, axi_rsp.w_ready);
    @(posedge clk);
    axi_req.aw_valid <= 1'b0;
    aw_sent = 1'b1;
    for (int i = 0; i < beats; i++) begin
      w.data = lcg_next();
      rnd    = lcg_next();
      w.strb = rnd[StrbWidth-1:0];
      w.last = (i == beats - 1);
      if (i > 0) @(posedge clk);
      axi_req.w       <= w;
      axi_req.w_valid <= 1'b1;
      @(negedge clk);
      while (!axi_rsp.w_ready) @(negedge clk);
      // W beats follow the route of their AW
      exp = make_req_flit(ChW, dst, w.last, '0, '0, '0, w.data, w.strb);
      check_req_flit("floo_req_o.flit", exp, floo_req.flit);
      check_bit("aw_ready", 1'b0, axi_rsp.aw_ready);
    end
    @(posedge clk);
    axi_req.w_valid <= 1'b0;
    w_last_time = $time;
  endtask

  task automatic send_r_beat(input logic [IdWidth-1:0] id, input logic last);
    rsp_flit_t f;
    axi_r_t    exp;
    f            = '0;
    f.hdr.dst_id = node_id;
    f.hdr.src_id = 2'd2;
    f.hdr.axi_ch = ChR;
    f.hdr.last   = last;
    f.id         = id;
    f.data       = lcg_next();
    f.resp       = 2'b01;
    exp.id   = id;
    exp.data = f.data;
    exp.resp = f.resp;
    exp.last = last;
    @(posedge clk);
    floo_rsp.flit   <= f;
    floo_rsp.valid  <= 1'b1;
    axi_req.r_ready <= 1'b1;
    @(negedge clk);
    check_bit("r_valid", 1'b1, axi_rsp.r_valid);
    check_bit("floo_rsp_ready_o", 1'b1, floo_rsp_ready);
    check_r("axi_in_rsp_o.r", exp, axi_rsp.r);
    @(posedge clk);
    floo_rsp.valid  <= 1'b0;
    axi_req.r_ready <= 1'b0;
    if (last) reads_open--;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_single_read();
    axi_ar_t ar;
    @(negedge clk);
    check_bit("floo_req_o.valid", 1'b0, floo_req.valid);
    check_bit("b_valid", 1'b0, axi_rsp.b_valid);
    check_bit("r_valid", 1'b0, axi_rsp.r_valid);
    ar.addr = make_addr(2'd2, 28'h000_0140);
    ar.id   = 4'h5;
    ar.len  = 8'd3;
    start_read(ar);
    finish_read(ar, 2'd2);
  endtask

  task automatic test_write_burst();
    write_burst(2'd3, 28'h010_0000, 4'hA, 3);
  endtask

  task automatic test_read_behind_write();
    axi_ar_t ar;
    ar.addr = make_addr(2'd0, 28'h000_0400);
    ar.id   = 4'h1;
    ar.len  = 8'd0;
    aw_sent = 1'b0;
    fork
      write_burst(2'd1, 28'h000_2000, 4'h2, 2);
      begin
        wait (aw_sent);
        start_read(ar);
        finish_read(ar, 2'd0);
      end
    join
    checks++;
    if (ar_time <= w_last_time) begin
      errors++;
      $display("Read left at %0t before the write burst ended at %0t", ar_time, w_last_time);
    end
  endtask

  task automatic test_link_stall();
    axi_ar_t   ar;
    req_flit_t exp;
    ar.addr = make_addr(2'd1, 28'h123_4560);
    ar.id   = 4'h9;
    ar.len  = 8'd1;
    exp     = make_req_flit(ChAr, 2'd1, 1'b1, ar.addr, ar.id, ar.len, '0, '0);
    start_read(ar);
    floo_req_ready <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit("floo_req_o.valid", 1'b1, floo_req.valid);
      check_bit("ar_ready", 1'b0, axi_rsp.ar_ready);
      check_req_flit("floo_req_o.flit", exp, floo_req.flit);
    end
    @(posedge clk);
    floo_req_ready <= 1'b1;
    finish_read(ar, 2'd1);
  endtask

  task automatic test_responses();
    rsp_flit_t f;
    axi_b_t    exp;
    f            = '0;
    f.hdr.dst_id = node_id;
    f.hdr.src_id = 2'd3;
    f.hdr.axi_ch = ChB;
    f.hdr.last   = 1'b1;
    f.id         = 4'hA;
    f.resp       = 2'b10;
    exp.id       = f.id;
    exp.resp     = f.resp;
    // Core holds off the B beat first
    @(posedge clk);
    floo_rsp.flit   <= f;
    floo_rsp.valid  <= 1'b1;
    axi_req.b_ready <= 1'b0;
    @(negedge clk);
    check_bit("b_valid", 1'b1, axi_rsp.b_valid);
    check_bit("floo_rsp_ready_o", 1'b0, floo_rsp_ready);
    @(posedge clk);
    axi_req.b_ready <= 1'b1;
    @(negedge clk);
    check_b("axi_in_rsp_o.b", exp, axi_rsp.b);
    check_bit("floo_rsp_ready_o", 1'b1, floo_rsp_ready);
    @(posedge clk);
    floo_rsp.valid  <= 1'b0;
    axi_req.b_ready <= 1'b0;
    send_r_beat(4'h5, 1'b0);
    send_r_beat(4'h5, 1'b1);
  endtask

  task automatic test_read_limit();
    axi_ar_t ar;
    ar.addr = make_addr(2'd2, 28'h000_0800);
    ar.id   = 4'h7;
    ar.len  = 8'd0;
    while (reads_open < int'(MaxTxns)) begin
      start_read(ar);
      finish_read(ar, 2'd2);
    end
    // One read past the limit
    start_read(ar);
    repeat (4) begin
      @(negedge clk);
      check_bit("ar_ready", 1'b0, axi_rsp.ar_ready);
      check_bit("floo_req_o.valid", 1'b0, floo_req.valid);
    end
    send_r_beat(4'h7, 1'b1);
    finish_read(ar, 2'd2);
  endtask

  initial begin
    lcg_state      = 32'h044d_9048;
    errors         = 0;
    checks         = 0;
    reads_open     = 0;
    aw_sent        = 1'b0;
    w_last_time    = 0;
    ar_time        = 0;
    reset          = 1'b1;
    node_id        = 2'd1;
    axi_req        = '0;
    floo_req_ready = 1'b1;
    floo_rsp       = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_single_read();
    test_write_burst();
    test_read_behind_write();
    test_link_stall();
    test_responses();
    test_read_limit();
    repeat (2) @(posedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== write_packer.sv ====
////////////////////////////////////////////////////////////
// Packs an AW beat and its W burst into one wormhole packet
// and limits the number of writes waiting for a B response.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module write_packer import chimney_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  node_id_t  node_id_i,
  input  axi_aw_t   aw_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_w_t    w_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  input  logic      b_done_i,
  output req_flit_t flit_o,
  output logic      flit_valid_o,
  input  logic      flit_ready_i
);

  typedef enum logic {
    PhaseAw,
    PhaseW
  } phase_e;

  phase_e              phase_q, phase_d;
  logic [CntWidth-1:0] cnt_q, cnt_d;
  node_id_t            dst_q;
  logic                full;
  logic                aw_fire, w_fire;

  assign full = (cnt_q == CntWidth'(MaxTxns));

  // AW waits for a free slot, W follows once its AW is out
  assign flit_valid_o = (phase_q == PhaseAw) ? (aw_valid_i && !full) : w_valid_i;
  assign aw_ready_o   = (phase_q == PhaseAw) && !full && flit_ready_i;
  assign w_ready_o    = (phase_q == PhaseW) && flit_ready_i;

  assign aw_fire = aw_valid_i && aw_ready_o;
  assign w_fire  = w_valid_i && w_ready_o;

  always_comb begin
    flit_o            = '0;
    flit_o.hdr.src_id = node_id_i;
    if (phase_q == PhaseAw) begin
      flit_o.hdr.dst_id = addr_to_node(aw_i.addr);
      flit_o.hdr.axi_ch = ChAw;
      flit_o.hdr.last   = 1'b0;
      flit_o.addr       = aw_i.addr;
      flit_o.id         = aw_i.id;
      flit_o.len        = aw_i.len;
    end else begin
      // W beats reuse the route of their AW
      flit_o.hdr.dst_id = dst_q;
      flit_o.hdr.axi_ch = ChW;
      flit_o.hdr.last   = w_i.last;
      flit_o.data       = w_i.data;
      flit_o.strb       = w_i.strb;
    end
  end

  always_comb begin
    phase_d = phase_q;
    if (aw_fire) phase_d = PhaseW;
    if (w_fire && w_i.last) phase_d = PhaseAw;
  end

  always_comb begin
    case ({aw_fire, b_done_i})
      2'b10:   cnt_d = cnt_q + CntWidth'(1);
      2'b01:   cnt_d = cnt_q - CntWidth'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_q <= PhaseAw;
      cnt_q   <= '0;
    end else begin
      phase_q <= phase_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) dst_q <= addr_to_node(aw_i.addr);
  end

  // A W beat waiting in the AW phase or on the link stays unchanged
  w_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    w_valid_i && !w_ready_o |=> w_valid_i && $stable(w_i));

  cnt_limit_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cnt_q <= CntWidth'(MaxTxns));

endmodule
